//--- awg_table.sv
// waveform sample memory, written from the register port,
// read through one register that also carries the frame-start mark
`timescale 1ns/100ps
`default_nettype none
`include "tx_params.svh"

module awg_table
  import tx_sample_pkg::*;
(
  input  wire logic                          ps_clk,
  input  wire logic                          reset_i,
  input  wire logic                          wr_en_i,
  input  wire logic [`TX_AWG_ADDR_WIDTH-1:0] wr_addr_i,
  input  wire sample_t                       wr_data_i,
  input  wire logic                          rd_en_i,
  input  wire logic [`TX_AWG_ADDR_WIDTH-1:0] rd_addr_i,
  input  wire logic                          frame_start_i,
  output tagged_sample_t                     sample_o
);

  sample_t        mem [`TX_AWG_DEPTH];
  tagged_sample_t sample_q;

  // write port
  always_ff @(posedge ps_clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read
  // idle table reads as zero with no mark
  always_ff @(posedge ps_clk) begin
    if (reset_i) begin
      sample_q <= '0;
    end else if (rd_en_i) begin
      sample_q.sample <= mem[rd_addr_i];
      sample_q.mark   <= frame_start_i;
    end else begin
      sample_q <= '0;
    end
  end

  assign sample_o = sample_q;

endmodule

`default_nettype wire

//--- files.f
+incdir+.
tx_sample_pkg.sv
tx_config_pkg.sv
tx_control.sv
awg_table.sv
triangle_gen.sv
scale_offset.sv
transmit_top.sv
transmit_top_assertions.sv
transmit_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the transmit chain testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module transmit_top_tb \
  -o transmit_top_tb > sim.log 2>&1 \
  && ./obj_dir/transmit_top_tb >> sim.log 2>&1 \
  || echo "Errors found" >> sim.log
grep -q "Errors found" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- scale_offset.sv
// source select and trigger pick, then scale, offset and saturate,
// two register stages from source to output
`timescale 1ns/100ps
`default_nettype none
`include "tx_params.svh"

module scale_offset
  import tx_sample_pkg::*;
  import tx_config_pkg::*;
(
  input  wire logic           ps_clk,
  input  wire logic           reset_i,
  input  wire tx_config_t     config_i,
  input  wire tagged_sample_t awg_i,
  input  wire tagged_sample_t tri_i,
  output sample_t             data_o,
  output logic                trigger_o
);

  localparam int ProdWidth   = `TX_SAMPLE_WIDTH + `TX_SCALE_WIDTH;
  localparam int ScaledWidth = ProdWidth - `TX_SCALE_FRAC_BITS;
  localparam sample_t SampleMax = {1'b0, {(`TX_SAMPLE_WIDTH-1){1'b1}}};
  localparam sample_t SampleMin = {1'b1, {(`TX_SAMPLE_WIDTH-1){1'b0}}};

  sample_t                          sel_q;
  logic                             trig_q;
  tagged_sample_t                   sel;
  logic                             trig;
  logic signed [ProdWidth-1:0]      product;
  logic signed [ScaledWidth-1:0]    scaled;
  logic signed [ScaledWidth:0]      sum;
  sample_t                          sat;
  sample_t                          data_q;
  logic                             trigger_q;

  // stage one picks the source and its mark
  always_comb begin
    case (config_i.source)
      SRC_AWG: sel = awg_i;
      SRC_TRI: sel = tri_i;
      default: sel = '0;
    endcase
  end

  // trigger only from the source that trig_src names
  assign trig = sel.mark && (config_i.trig_src ? (config_i.source == SRC_TRI)
                                               : (config_i.source == SRC_AWG));

  // stage two arithmetic
  // dropping the low bits floors toward minus infinity
  assign product = $signed(sel_q) * $signed(config_i.scale);
  assign scaled  = product[ProdWidth-1:`TX_SCALE_FRAC_BITS];
  assign sum     = $signed(scaled) + $signed(config_i.offset);

  always_comb begin
    if (sum > $signed(SampleMax)) begin
      sat = SampleMax;
    end else if (sum < $signed(SampleMin)) begin
      sat = SampleMin;
    end else begin
      sat = sum[`TX_SAMPLE_WIDTH-1:0];
    end
  end

  always_ff @(posedge ps_clk) begin
    if (reset_i) begin
      sel_q     <= '0;
      trig_q    <= 1'b0;
      data_q    <= '0;
      trigger_q <= 1'b0;
    end else begin
      sel_q     <= sel.sample;
      trig_q    <= trig;
      data_q    <= sat;
      trigger_q <= trig_q;
    end
  end

  assign data_o    = data_q;
  assign trigger_o = trigger_q;

endmodule

`default_nettype wire

//--- transmit_top.sv
// transmit chain top: register control, waveform table,
// triangle generator and output prescaler
`timescale 1ns/100ps
`default_nettype none
`include "tx_params.svh"

module transmit_top
  import tx_sample_pkg::*;
  import tx_config_pkg::*;
(
  input  wire logic      ps_clk,
  input  wire logic      reset_i,
  input  wire logic      cfg_write_i,
  input  wire cfg_addr_t cfg_addr_i,
  input  wire cfg_data_t cfg_data_i,
  output sample_t        data_o,
  output logic           trigger_o,
  output logic           busy_o
);

  tx_config_t                    tx_config;
  logic                          awg_wr_en;
  logic [`TX_AWG_ADDR_WIDTH-1:0] awg_wr_addr;
  sample_t                       awg_wr_data;
  logic                          awg_rd_en;
  logic [`TX_AWG_ADDR_WIDTH-1:0] awg_rd_addr;
  logic                          awg_frame_start;
  logic                          tri_enable;
  tagged_sample_t                awg_sample;
  tagged_sample_t                tri_sample;

  // triangle only runs while selected
  assign tri_enable = (tx_config.source == SRC_TRI);

  tx_control i_tx_control (
    .ps_clk            (ps_clk),
    .reset_i           (reset_i),
    .cfg_write_i       (cfg_write_i),
    .cfg_addr_i        (cfg_addr_i),
    .cfg_data_i        (cfg_data_i),
    .config_o          (tx_config),
    .awg_wr_en_o       (awg_wr_en),
    .awg_wr_addr_o     (awg_wr_addr),
    .awg_wr_data_o     (awg_wr_data),
    .awg_rd_en_o       (awg_rd_en),
    .awg_rd_addr_o     (awg_rd_addr),
    .awg_frame_start_o (awg_frame_start),
    .busy_o            (busy_o)
  );

  awg_table i_awg_table (
    .ps_clk        (ps_clk),
    .reset_i       (reset_i),
    .wr_en_i       (awg_wr_en),
    .wr_addr_i     (awg_wr_addr),
    .wr_data_i     (awg_wr_data),
    .rd_en_i       (awg_rd_en),
    .rd_addr_i     (awg_rd_addr),
    .frame_start_i (awg_frame_start),
    .sample_o      (awg_sample)
  );

  triangle_gen i_triangle_gen (
    .ps_clk      (ps_clk),
    .reset_i     (reset_i),
    .enable_i    (tri_enable),
    .phase_inc_i (tx_config.tri_inc),
    .sample_o    (tri_sample)
  );

  scale_offset i_scale_offset (
    .ps_clk    (ps_clk),
    .reset_i   (reset_i),
    .config_i  (tx_config),
    .awg_i     (awg_sample),
    .tri_i     (tri_sample),
    .data_o    (data_o),
    .trigger_o (trigger_o)
  );

endmodule

`default_nettype wire

//--- transmit_top_assertions.sv
// concurrent checks on the trigger pulse, busy flag
// and the AWG sequencer state around reset
`timescale 1ns/100ps
`default_nettype none

module transmit_top_assertions
  import tx_config_pkg::*;
(
  input wire logic       ps_clk,
  input wire logic       reset_i,
  input wire logic       trigger_i,
  input wire logic       busy_i,
  input wire awg_state_e awg_state_i
);

  // frames and triangle periods are longer than one sample
  assert property (@(posedge ps_clk) disable iff (reset_i) trigger_i |=> !trigger_i)
    else $error("trigger high in two consecutive cycles");

  // busy cleared by every reset edge
  assert property (@(posedge ps_clk) reset_i |=> !busy_i)
    else $error("busy high during reset");

  assert property (@(posedge ps_clk) $fell(reset_i) |-> awg_state_i == AWG_IDLE)
    else $error("AWG sequencer not idle after reset");

endmodule

`default_nettype wire

//--- transmit_top_tb.sv
// directed tests for the transmit chain: reset, AWG bursts,
// prescaler arithmetic, triangle shape and burst stop
`timescale 1ns/100ps
`default_nettype none
`include "tx_params.svh"

module transmit_top_tb
  import tx_sample_pkg::*;
  import tx_config_pkg::*;
();

  localparam int TimeoutCycles = 4000;

  logic      ps_clk;
  logic      reset_i;
  logic      cfg_write_i;
  cfg_addr_t cfg_addr_i;
  cfg_data_t cfg_data_i;
  sample_t   data_o;
  logic      trigger_o;
  logic      busy_o;
  sample_t   awg_model [`TX_AWG_DEPTH];
  int        cycle_count = 0;

  transmit_top i_transmit_top (
    .ps_clk      (ps_clk),
    .reset_i     (reset_i),
    .cfg_write_i (cfg_write_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_data_i  (cfg_data_i),
    .data_o      (data_o),
    .trigger_o   (trigger_o),
    .busy_o      (busy_o)
  );

  bind transmit_top transmit_top_assertions i_transmit_top_assertions (
    .ps_clk      (ps_clk),
    .reset_i     (reset_i),
    .trigger_i   (trigger_o),
    .busy_i      (busy_o),
    .awg_state_i (i_tx_control.state_q)
  );

  initial begin
    ps_clk = 1'b0;
    forever #2 ps_clk = ~ps_clk;
  end

  initial begin
    while (cycle_count < TimeoutCycles) begin
      @(posedge ps_clk);
      cycle_count++;
    end
    $display("Errors found");
    $fatal(1, "simulation did not finish within %0d cycles", TimeoutCycles);
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "stopping at first failure");
  endtask

  // one-cycle strobe sampled at the edge on which the task returns
  task automatic write_register(input cfg_addr_t addr, input int data);
    @(posedge ps_clk);
    cfg_write_i <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_data_i  <= cfg_data_t'(data);
    @(posedge ps_clk);
    cfg_write_i <= 1'b0;
  endtask

  // Q2.14 scale, floor on the shift, offset, clamp to 16 signed bits
  function automatic sample_t expected_output(input int sample, input int scale,
                                              input int offset);
    int value;
    value = (sample * scale) >>> `TX_SCALE_FRAC_BITS;
    value = value + offset;
    if (value > 32767) begin
      value = 32767;
    end else if (value < -32768) begin
      value = -32768;
    end
    return sample_t'(value);
  endfunction

  task automatic load_table();
    int k;
    write_register(`TX_REG_AWG_PTR, 0);
    for (k = 0; k < `TX_AWG_DEPTH; k++) begin
      awg_model[k] = sample_t'($urandom());
      write_register(`TX_REG_AWG_DATA, int'(awg_model[k]));
    end
  endtask

  task automatic play_frames(input int frames, input int last_addr, input int scale,
                             input int offset);
    int total;
    int i;
    int frame_len;
    frame_len = last_addr + 1;
    total = frames * frame_len;
    write_register(`TX_REG_SCALE, scale);
    write_register(`TX_REG_OFFSET, offset);
    write_register(`TX_REG_AWG_LENGTH, last_addr);
    write_register(`TX_REG_AWG_BURST, frames);
    // address, table read and one prescaler stage before the first sample
    repeat (3) @(negedge ps_clk);
    for (i = 0; i < total; i++) begin
      @(negedge ps_clk);
      check_value("data_o", data_o, expected_output(awg_model[i % frame_len], scale, offset));
      check_value("trigger_o", trigger_o, (i % frame_len) == 0);
      check_value("busy_o", busy_o, i < total - 3);
    end
    @(negedge ps_clk);
    check_value("data_o", data_o, expected_output(0, scale, offset));
    check_value("busy_o", busy_o, 1'b0);
  endtask

  task automatic test_reset_state();
    @(negedge ps_clk);
    check_value("data_o", data_o, 0);
    check_value("trigger_o", trigger_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    write_register(`TX_REG_OFFSET, 100);
    repeat (2) @(negedge ps_clk);
    check_value("data_o", data_o, expected_output(0, 0, 100));
  endtask

  task automatic test_awg_burst();
    load_table();
    write_register(`TX_REG_SOURCE, int'(SRC_AWG));
    write_register(`TX_REG_TRIG_SRC, 0);
    play_frames(3, 7, 16384, 100);
  endtask

  task automatic test_scale_offset();
    int scales [3] = '{8192, 28672, -16384};
    int offsets [2] = '{8191, -8191};
    int s;
    int o;
    load_table();
    for (s = 0; s < 3; s++) begin
      for (o = 0; o < 2; o++) begin
        play_frames(1, 7, scales[s], offsets[o]);
      end
    end
  endtask

  // 2^16 per cycle gives a 256-cycle period and 512 per step
  task automatic test_triangle();
    int waited;
    int j;
    int idx;
    int prev;
    int step;
    write_register(`TX_REG_SCALE, 16384);
    write_register(`TX_REG_OFFSET, 0);
    write_register(`TX_REG_TRI_INC, 32'h0001_0000);
    write_register(`TX_REG_TRIG_SRC, 1);
    write_register(`TX_REG_SOURCE, int'(SRC_TRI));
    waited = 0;
    @(negedge ps_clk);
    while (!trigger_o) begin
      if (waited > 300) begin
        stop_on_failure("triangle trigger did not appear within 300 cycles");
      end
      waited++;
      @(negedge ps_clk);
    end
    check_value("data_o", data_o, sample_t'(-32768));
    prev = int'(data_o);
    for (j = 1; j < 512; j++) begin
      @(negedge ps_clk);
      idx = j % 256;
      // wrap and peak are one short of a full step
      if (idx == 0) begin
        step = -511;
      end else if (idx == 128) begin
        step = 511;
      end else if (idx < 128) begin
        step = 512;
      end else begin
        step = -512;
      end
      check_value("trigger_o", trigger_o, idx == 0);
      check_value("data_o step", int'(data_o) - prev, step);
      prev = int'(data_o);
    end
  endtask

  task automatic test_stop_and_select();
    int i;
    write_register(`TX_REG_OFFSET, 1234);
    write_register(`TX_REG_TRIG_SRC, 0);
    write_register(`TX_REG_SOURCE, int'(SRC_AWG));
    write_register(`TX_REG_AWG_LENGTH, 15);
    write_register(`TX_REG_AWG_BURST, 4);
    repeat (12) @(negedge ps_clk);
    check_value("busy_o", busy_o, 1'b1);
    write_register(`TX_REG_AWG_BURST, 0);
    @(negedge ps_clk);
    check_value("busy_o", busy_o, 1'b0);
    repeat (3) @(negedge ps_clk);
    check_value("data_o", data_o, expected_output(0, 16384, 1234));
    // triangle wraps, but the trigger still points at the AWG
    write_register(`TX_REG_SOURCE, int'(SRC_TRI));
    for (i = 0; i < 300; i++) begin
      @(negedge ps_clk);
      check_value("trigger_o", trigger_o, 1'b0);
    end
  endtask

  initial begin
    void'($urandom(32'hf822_2962));
    reset_i     = 1'b1;
    cfg_write_i = 1'b0;
    cfg_addr_i  = '0;
    cfg_data_i  = '0;
    repeat (8) @(posedge ps_clk);
    reset_i <= 1'b0;
    test_reset_state();
    test_awg_burst();
    test_scale_offset();
    test_triangle();
    test_stop_and_select();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- triangle_gen.sv
// phase accumulator folded into a signed full-scale triangle,
// marking the cycle after each accumulator wrap
`timescale 1ns/100ps
`default_nettype none
`include "tx_params.svh"

module triangle_gen
  import tx_sample_pkg::*;
(
  input  wire logic   ps_clk,
  input  wire logic   reset_i,
  input  wire logic   enable_i,
  input  wire phase_t phase_inc_i,
  output tagged_sample_t sample_o
);

  phase_t                      phase_q;
  logic                        wrap_q;
  logic [`TX_PHASE_WIDTH:0]    phase_sum;
  logic [`TX_SAMPLE_WIDTH-1:0] fold;

  // extra bit holds the carry out
  assign phase_sum = {1'b0, phase_q} + {1'b0, phase_inc_i};

  always_ff @(posedge ps_clk) begin
    if (reset_i) begin
      phase_q <= '0;
      wrap_q  <= 1'b0;
    end else if (enable_i) begin
      phase_q <= phase_sum[`TX_PHASE_WIDTH-1:0];
      wrap_q  <= phase_sum[`TX_PHASE_WIDTH];
    end else begin
      wrap_q <= 1'b0;
    end
  end

  // top bit picks rising or falling half
  assign fold = phase_q[`TX_PHASE_WIDTH-1]
              ? ~phase_q[`TX_PHASE_WIDTH-2 -: `TX_SAMPLE_WIDTH]
              : phase_q[`TX_PHASE_WIDTH-2 -: `TX_SAMPLE_WIDTH];

  // offset binary to two's complement
  assign sample_o.sample = {~fold[`TX_SAMPLE_WIDTH-1], fold[`TX_SAMPLE_WIDTH-2:0]};
  assign sample_o.mark   = wrap_q;

endmodule

`default_nettype wire

//--- tx_config_pkg.sv
// configuration types: write port, source select, AWG sequencer state
// and the register struct handed to the datapath
`default_nettype none
`include "tx_params.svh"

package tx_config_pkg;

  import tx_sample_pkg::*;

  typedef logic [`TX_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
  typedef logic [`TX_CFG_DATA_WIDTH-1:0] cfg_data_t;

  typedef enum logic [1:0] {
    SRC_OFF = 2'd0,
    SRC_AWG = 2'd1,
    SRC_TRI = 2'd2
  } tx_source_e;

  typedef enum logic {
    AWG_IDLE = 1'b0,
    AWG_PLAY = 1'b1
  } awg_state_e;

  // trig_src: 0 = AWG frame start, 1 = triangle wrap
  typedef struct packed {
    tx_source_e source;
    phase_t     tri_inc;
    scale_t     scale;
    offset_t    offset;
    logic       trig_src;
  } tx_config_t;

endpackage

`default_nettype wire

//--- tx_control.sv
// register decode, AWG write pointer and the burst sequencer
// that walks the table read address frame by frame
`timescale 1ns/100ps
`default_nettype none
`include "tx_params.svh"

module tx_control
  import tx_sample_pkg::*;
  import tx_config_pkg::*;
(
  input  wire logic                          ps_clk,
  input  wire logic                          reset_i,
  input  wire logic                          cfg_write_i,
  input  wire cfg_addr_t                     cfg_addr_i,
  input  wire cfg_data_t                     cfg_data_i,
  output tx_config_t                         config_o,
  output logic                               awg_wr_en_o,
  output logic [`TX_AWG_ADDR_WIDTH-1:0]      awg_wr_addr_o,
  output sample_t                            awg_wr_data_o,
  output logic                               awg_rd_en_o,
  output logic [`TX_AWG_ADDR_WIDTH-1:0]      awg_rd_addr_o,
  output logic                               awg_frame_start_o,
  output logic                               busy_o
);

  tx_config_t                      config_q;
  logic [`TX_AWG_ADDR_WIDTH-1:0]   wr_ptr_q;
  logic [`TX_AWG_ADDR_WIDTH-1:0]   length_q;
  logic [`TX_AWG_ADDR_WIDTH-1:0]   rd_addr_q;
  logic [`TX_BURST_WIDTH-1:0]      frames_q;
  awg_state_e                      state_q;
  logic                            burst_write;
  logic [`TX_BURST_WIDTH-1:0]      burst_count;

  assign burst_write = cfg_write_i && (cfg_addr_i == `TX_REG_AWG_BURST);
  assign burst_count = cfg_data_i[`TX_BURST_WIDTH-1:0];

  // register file and write pointer
  always_ff @(posedge ps_clk) begin
    if (reset_i) begin
      config_q <= '0;
      wr_ptr_q <= '0;
      length_q <= '0;
    end else if (cfg_write_i) begin
      case (cfg_addr_i)
        `TX_REG_SOURCE:     config_q.source <= tx_source_e'(cfg_data_i[1:0]);
        `TX_REG_TRI_INC:    config_q.tri_inc <= cfg_data_i[`TX_PHASE_WIDTH-1:0];
        `TX_REG_SCALE:      config_q.scale <= cfg_data_i[`TX_SCALE_WIDTH-1:0];
        `TX_REG_OFFSET:     config_q.offset <= cfg_data_i[`TX_OFFSET_WIDTH-1:0];
        `TX_REG_TRIG_SRC:   config_q.trig_src <= cfg_data_i[0];
        `TX_REG_AWG_LENGTH: length_q <= cfg_data_i[`TX_AWG_ADDR_WIDTH-1:0];
        `TX_REG_AWG_DATA:   wr_ptr_q <= wr_ptr_q + 1'b1;
        `TX_REG_AWG_PTR:    wr_ptr_q <= cfg_data_i[`TX_AWG_ADDR_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // burst sequencer
  // a burst write restarts from address 0, a zero count stops at once
  always_ff @(posedge ps_clk) begin
    if (reset_i) begin
      state_q   <= AWG_IDLE;
      rd_addr_q <= '0;
      frames_q  <= '0;
    end else if (burst_write) begin
      rd_addr_q <= '0;
      frames_q  <= burst_count;
      state_q   <= (burst_count != '0) ? AWG_PLAY : AWG_IDLE;
    end else if (state_q == AWG_PLAY) begin
      if (rd_addr_q == length_q) begin
        // end of frame
        rd_addr_q <= '0;
        frames_q  <= frames_q - 1'b1;
        if (frames_q == 1) begin
          state_q <= AWG_IDLE;
        end
      end else begin
        rd_addr_q <= rd_addr_q + 1'b1;
      end
    end
  end

  assign config_o          = config_q;
  assign awg_wr_en_o       = cfg_write_i && (cfg_addr_i == `TX_REG_AWG_DATA);
  assign awg_wr_addr_o     = wr_ptr_q;
  assign awg_wr_data_o     = sample_t'(cfg_data_i[`TX_SAMPLE_WIDTH-1:0]);
  assign awg_rd_en_o       = (state_q == AWG_PLAY);
  assign awg_rd_addr_o     = rd_addr_q;
  assign awg_frame_start_o = (state_q == AWG_PLAY) && (rd_addr_q == '0);
  assign busy_o            = (state_q == AWG_PLAY);

endmodule

`default_nettype wire

//--- tx_params.svh
// widths, table depth, register map and fixed-point position
// for the single-channel transmit chain
`ifndef TX_PARAMS_SVH
`define TX_PARAMS_SVH

// configuration write port
`define TX_CFG_ADDR_WIDTH 4
`define TX_CFG_DATA_WIDTH 32

// datapath widths
`define TX_SAMPLE_WIDTH 16
`define TX_PHASE_WIDTH 24
`define TX_SCALE_WIDTH 16
// scale is signed Q2.14, unity = 16384
`define TX_SCALE_FRAC_BITS 14
`define TX_OFFSET_WIDTH 14

// waveform table and burst counter
`define TX_AWG_DEPTH 16
`define TX_AWG_ADDR_WIDTH 4
`define TX_BURST_WIDTH 16

// register addresses
`define TX_REG_SOURCE 4'd0
`define TX_REG_TRI_INC 4'd1
`define TX_REG_SCALE 4'd2
`define TX_REG_OFFSET 4'd3
`define TX_REG_AWG_DATA 4'd4
`define TX_REG_AWG_LENGTH 4'd5
`define TX_REG_AWG_BURST 4'd6
`define TX_REG_TRIG_SRC 4'd7
`define TX_REG_AWG_PTR 4'd8

`endif

//--- tx_sample_pkg.sv
// datapath types: sample, phase, scale, offset
// and a sample carrying a one-bit mark
`default_nettype none
`include "tx_params.svh"

package tx_sample_pkg;

  typedef logic signed [`TX_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`TX_PHASE_WIDTH-1:0] phase_t;
  typedef logic signed [`TX_SCALE_WIDTH-1:0] scale_t;
  typedef logic signed [`TX_OFFSET_WIDTH-1:0] offset_t;

  // mark is a frame start (table) or a phase wrap (triangle)
  typedef struct packed {
    sample_t sample;
    logic    mark;
  } tagged_sample_t;

endpackage

`default_nettype wire
